// File: src/lc3b_pkg.sv
package lc3b_pkg;

	// Processor word, used for both addresses and data
	typedef logic [15:0] lc3b_word;

	// One cache block, the unit of every L2 transfer
	typedef logic [255:0] lc3b_block;

endpackage : lc3b_pkg

// File: src/l2_cache_pkg.sv
package l2_cache_pkg;

	// Geometry
	localparam int num_sets    = 8;
	localparam int num_ways    = 2;       // LRU logic assumes exactly two

	// Address split, tag | index | offset
	localparam int offset_bits = 5;       // 32-byte block
	localparam int index_bits  = 3;
	localparam int tag_bits    = 8;

	typedef logic [tag_bits-1:0]   l2_tag;
	typedef logic [index_bits-1:0] l2_index;

	// Processor-side request, levels held until mem_resp
	typedef struct packed {
		logic                 read;
		logic                 write;
		lc3b_pkg::lc3b_word  address;
		lc3b_pkg::lc3b_block wdata;
	} l2_req;

	// Physical memory request, held until pmem_resp
	typedef struct packed {
		logic                 read;
		logic                 write;
		lc3b_pkg::lc3b_word  address;
		lc3b_pkg::lc3b_block wdata;
	} pmem_req;

	// Control to datapath
	typedef struct packed {
		logic load_hit_write;             // Store req.wdata into hit way
		logic load_fill;                  // Store pmem_rdata into LRU way
		logic touch_lru;                  // Hit access, flip LRU away from hit way
		logic addr_victim;                // pmem address from victim tag
	} l2_ctrl;

	// Datapath to control
	typedef struct packed {
		logic hit;
		logic victim_dirty;
	} l2_status;

	typedef enum logic [1:0] {
		s_compare,
		s_writeback,
		s_fill
	} l2_state;

endpackage : l2_cache_pkg

// File: src/l2_cache_datapath.sv
`timescale 1ns/1ns

module l2_cache_datapath (
	input  logic                    clk,
	input  logic                    reset,
	input  l2_cache_pkg::l2_req     req,
	input  l2_cache_pkg::l2_ctrl    ctrl,
	input  lc3b_pkg::lc3b_block     pmem_rdata,
	output l2_cache_pkg::l2_status  status,
	output lc3b_pkg::lc3b_block     mem_rdata,
	output lc3b_pkg::lc3b_word      pmem_address,
	output lc3b_pkg::lc3b_block     pmem_wdata
);

	// Request address fields
	l2_cache_pkg::l2_tag   tag;
	l2_cache_pkg::l2_index index;

	// Storage arrays
	lc3b_pkg::lc3b_block   data_array  [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
	l2_cache_pkg::l2_tag   tag_array   [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
	logic [l2_cache_pkg::num_ways-1:0] valid_array [l2_cache_pkg::num_sets];
	logic [l2_cache_pkg::num_ways-1:0] dirty_array [l2_cache_pkg::num_sets];
	logic [l2_cache_pkg::num_sets-1:0] lru_array;     // One bit per set, names LRU way

	// Way selection
	logic [l2_cache_pkg::num_ways-1:0] way_hit;
	logic                  hit_way;                   // Way that matched
	logic                  lru_way;                   // Victim on a miss
	logic                  write_way;
	logic                  load_data;
	lc3b_pkg::lc3b_block   write_data;
	l2_cache_pkg::l2_tag   victim_tag;

	assign tag   = req.address[15 -: l2_cache_pkg::tag_bits];
	assign index = req.address[l2_cache_pkg::offset_bits +: l2_cache_pkg::index_bits];

	// Tag compare, qualified by valid
	always_comb begin
		for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
			way_hit[w] = valid_array[index][w] && (tag_array[index][w] == tag);
		end
	end

	assign hit_way    = way_hit[1];                   // Two ways, so way 1 or else way 0
	assign lru_way    = lru_array[index];
	assign victim_tag = tag_array[index][lru_way];

	assign status.hit          = |way_hit;
	assign status.victim_dirty = valid_array[index][lru_way] & dirty_array[index][lru_way];

	// Fill goes to the victim, a write hit to the matching way
	assign write_way  = ctrl.load_fill ? lru_way : hit_way;
	assign write_data = ctrl.load_fill ? pmem_rdata : req.wdata;
	assign load_data  = ctrl.load_fill | ctrl.load_hit_write;

	// Read data for the processor
	assign mem_rdata = data_array[index][hit_way];

	// Victim block on writeback, request block on fill
	always_comb begin
		if (ctrl.addr_victim) begin
			pmem_address = {victim_tag, index, {l2_cache_pkg::offset_bits{1'b0}}};
		end else begin
			pmem_address = {tag, index, {l2_cache_pkg::offset_bits{1'b0}}};
		end
	end

	assign pmem_wdata = data_array[index][lru_way];

	// Block and tag storage
	always_ff @(posedge clk) begin
		if (load_data) begin
			data_array[index][write_way] <= write_data;
		end
		if (ctrl.load_fill) begin
			tag_array[index][write_way] <= tag;      // New owner of the way
		end
	end

	// Valid, dirty and LRU state
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < l2_cache_pkg::num_sets; s++) begin
				valid_array[s] <= '0;
				dirty_array[s] <= '0;
			end
			lru_array <= '0;
		end else begin
			if (ctrl.load_fill) begin
				valid_array[index][write_way] <= 1'b1;
				dirty_array[index][write_way] <= 1'b0;  // Fresh from memory
			end else if (ctrl.load_hit_write) begin
				dirty_array[index][write_way] <= 1'b1;  // Differs from memory now
			end
			if (ctrl.touch_lru) begin
				lru_array[index] <= ~hit_way;           // Other way becomes LRU
			end
		end
	end

endmodule : l2_cache_datapath

// File: src/l2_cache_control.sv
`timescale 1ns/1ns

module l2_cache_control (
	input  logic                    clk,
	input  logic                    reset,
	input  l2_cache_pkg::l2_req     req,
	input  l2_cache_pkg::l2_status  status,
	input  logic                    pmem_resp,
	output l2_cache_pkg::l2_ctrl    ctrl,
	output logic                    mem_resp,
	output logic                    pmem_read,
	output logic                    pmem_write
);

	l2_cache_pkg::l2_state state;
	l2_cache_pkg::l2_state next_state;
	logic                  req_present;           // Read or write level from L1

	assign req_present = req.read | req.write;

	// State register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= l2_cache_pkg::s_compare;
		end else begin
			state <= next_state;
		end
	end

	// Next state and outputs
	always_comb begin
		next_state = state;                        // Hold by default
		ctrl       = '0;
		mem_resp   = 1'b0;
		pmem_read  = 1'b0;
		pmem_write = 1'b0;

		case (state)
			l2_cache_pkg::s_compare: begin
				if (req_present) begin
					if (status.hit) begin
						mem_resp            = 1'b1;        // Same cycle as the match
						ctrl.touch_lru      = 1'b1;
						ctrl.load_hit_write = req.write;   // Write hit stores at this edge
					end else if (status.victim_dirty) begin
						next_state = l2_cache_pkg::s_writeback;  // Save victim first
					end else begin
						next_state = l2_cache_pkg::s_fill;
					end
				end
			end

			l2_cache_pkg::s_writeback: begin
				pmem_write       = 1'b1;                 // Held until memory answers
				ctrl.addr_victim = 1'b1;                 // Victim tag on the address
				if (pmem_resp) begin
					next_state = l2_cache_pkg::s_fill;
				end
			end

			l2_cache_pkg::s_fill: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					ctrl.load_fill = 1'b1;              // Block lands at this edge
					next_state     = l2_cache_pkg::s_compare;  // Retry now hits
				end
			end

			default: begin
				next_state = l2_cache_pkg::s_compare;
			end
		endcase
	end

endmodule : l2_cache_control

// File: src/l2_cache.sv
`timescale 1ns/1ns

module l2_cache (
	input  logic                  clk,
	input  logic                  reset,
	input  l2_cache_pkg::l2_req   req,
	output logic                  mem_resp,
	output lc3b_pkg::lc3b_block   mem_rdata,
	output l2_cache_pkg::pmem_req pmem,
	input  logic                  pmem_resp,
	input  lc3b_pkg::lc3b_block   pmem_rdata
);

	l2_cache_pkg::l2_ctrl   ctrl;               // Control to datapath
	l2_cache_pkg::l2_status status;             // Datapath to control
	logic                   pmem_read;
	logic                   pmem_write;
	lc3b_pkg::lc3b_word     pmem_address;
	lc3b_pkg::lc3b_block    pmem_wdata;

	l2_cache_control control (
		.clk        (clk),
		.reset      (reset),
		.req        (req),
		.status     (status),
		.pmem_resp  (pmem_resp),
		.ctrl       (ctrl),
		.mem_resp   (mem_resp),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write)
	);

	l2_cache_datapath datapath (
		.clk          (clk),
		.reset        (reset),
		.req          (req),
		.ctrl         (ctrl),
		.pmem_rdata   (pmem_rdata),
		.status       (status),
		.mem_rdata    (mem_rdata),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata)
	);

	// Strobes from control, address and data from datapath
	assign pmem = '{
		read:    pmem_read,
		write:   pmem_write,
		address: pmem_address,
		wdata:   pmem_wdata
	};

endmodule : l2_cache

// File: tb/pmem_model.sv
`timescale 1ns/1ns

module pmem_model (
	input  logic                  clk,
	input  logic                  reset,
	input  l2_cache_pkg::pmem_req pmem,
	output logic                  pmem_resp,
	output lc3b_pkg::lc3b_block   pmem_rdata
);

	lc3b_pkg::lc3b_block   store [lc3b_pkg::lc3b_word];   // Only blocks written so far
	l2_cache_pkg::pmem_req access_log [$];                 // Completed accesses, oldest first
	int                    seed = 32'h84a4;
	int                    wait_cycles;                    // Cycles left before the answer
	logic                  busy;

	// Contents of a block never written, differs for every block address
	function automatic lc3b_pkg::lc3b_block fill_pattern(input lc3b_pkg::lc3b_word address);
		lc3b_pkg::lc3b_block b;
		for (int i = 0; i < 16; i++) begin
			b[i*16 +: 16] = (address ^ 16'ha5c3) + (16'(i) * 16'h0f1d);
		end
		return b;
	endfunction

	initial begin
		pmem_resp  = 1'b0;
		pmem_rdata = '0;
		busy       = 1'b0;
	end

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			pmem_resp   <= 1'b0;
			busy        <= 1'b0;
			wait_cycles <= 0;
		end else if (pmem_resp) begin
			pmem_resp <= 1'b0;                              // Cache leaves this strobe now
		end else if (!busy) begin
			if (pmem.read || pmem.write) begin
				busy        <= 1'b1;
				wait_cycles <= 1 + ($unsigned($random(seed)) % 4);   // 1 to 4 cycles
			end
		end else if (wait_cycles > 1) begin
			wait_cycles <= wait_cycles - 1;
		end else begin
			busy      <= 1'b0;
			pmem_resp <= 1'b1;                              // One-cycle answer
			access_log.push_back(pmem);
			if (pmem.write) begin
				store[pmem.address] = pmem.wdata;
			end else begin
				pmem_rdata <= store.exists(pmem.address) ? store[pmem.address]
					: fill_pattern(pmem.address);
			end
		end
	end

endmodule : pmem_model

// File: tb/l2_cache_tb.sv
`timescale 1ns/1ns

module l2_cache_tb;

	localparam int clk_period   = 100;
	localparam int num_requests = 221;                  // 21 directed plus 200 random
	localparam int watchdog_ns  = num_requests * (2 * 5 + 4) * clk_period + 50 * clk_period;

	// What one request should produce
	typedef struct packed {
		lc3b_pkg::lc3b_block rdata;
		logic                fill;
		logic                writeback;
		lc3b_pkg::lc3b_word  wb_address;
		lc3b_pkg::lc3b_block wb_data;
	} ref_result;

	logic                  clk;
	logic                  reset;
	l2_cache_pkg::l2_req   req;
	logic                  mem_resp;
	lc3b_pkg::lc3b_block   mem_rdata;
	l2_cache_pkg::pmem_req pmem;
	logic                  pmem_resp;
	lc3b_pkg::lc3b_block   pmem_rdata;

	// Reference cache state
	l2_cache_pkg::l2_tag   ref_tag  [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
	lc3b_pkg::lc3b_block   ref_data [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
	logic [1:0]            ref_valid [l2_cache_pkg::num_sets];
	logic [1:0]            ref_dirty [l2_cache_pkg::num_sets];
	logic [l2_cache_pkg::num_sets-1:0] ref_lru;          // Names the LRU way per set
	lc3b_pkg::lc3b_block   shadow [lc3b_pkg::lc3b_word]; // Memory after writebacks

	int seed       = 32'h84a4;
	int errors     = 0;
	int checks     = 0;
	int test_count = 0;
	int test_base  = 0;                                  // Errors before current test

	logic pmem_resp_prev = 1'b0;                         // pmem_resp one edge earlier
	int   req_cycles     = 0;                            // Edges a request waited unanswered

	l2_cache uut (
		.clk        (clk),
		.reset      (reset),
		.req        (req),
		.mem_resp   (mem_resp),
		.mem_rdata  (mem_rdata),
		.pmem       (pmem),
		.pmem_resp  (pmem_resp),
		.pmem_rdata (pmem_rdata)
	);

	pmem_model memory (
		.clk        (clk),
		.reset      (reset),
		.pmem       (pmem),
		.pmem_resp  (pmem_resp),
		.pmem_rdata (pmem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Two-way LRU, write-back, write-allocate; updates the reference state
	function automatic ref_result ref_access(input logic is_write,
			input lc3b_pkg::lc3b_word address, input lc3b_pkg::lc3b_block wdata);
		ref_result             r;
		l2_cache_pkg::l2_tag   tag;
		l2_cache_pkg::l2_index index;
		lc3b_pkg::lc3b_word    block_addr;
		logic                  way;
		r          = '0;
		tag        = address[15:8];
		index      = address[7:5];
		block_addr = {address[15:5], 5'b0};               // Offset ignored
		if (ref_valid[index][0] && ref_tag[index][0] == tag) begin
			way = 1'b0;
		end else if (ref_valid[index][1] && ref_tag[index][1] == tag) begin
			way = 1'b1;
		end else begin
			way = ref_lru[index];                             // Miss, LRU way is the victim
			if (ref_valid[index][way] && ref_dirty[index][way]) begin
				r.writeback  = 1'b1;
				r.wb_address = {ref_tag[index][way], index, 5'b0};
				r.wb_data    = ref_data[index][way];
				shadow[r.wb_address] = r.wb_data;
			end
			r.fill = 1'b1;
			ref_data[index][way] = shadow.exists(block_addr) ? shadow[block_addr]
				: memory.fill_pattern(block_addr);
			ref_tag[index][way]   = tag;
			ref_valid[index][way] = 1'b1;
			ref_dirty[index][way] = 1'b0;
		end
		r.rdata = ref_data[index][way];
		if (is_write) begin
			ref_data[index][way]  = wdata;
			ref_dirty[index][way] = 1'b1;
		end
		ref_lru[index] = ~way;                              // Other way is now LRU
		return r;
	endfunction

	task automatic check_block(input string name, input lc3b_pkg::lc3b_block got,
			input lc3b_pkg::lc3b_block expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic check_addr(input string name, input lc3b_pkg::lc3b_word got,
			input lc3b_pkg::lc3b_word expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, expected);
		end
	endtask

	// Compare every response, its latency and the memory traffic behind it
	always @(posedge clk) begin : compare
		ref_result exp;
		int        n;
		if (!reset && mem_resp) begin
			exp = ref_access(req.write, req.address, req.wdata);
			n   = 0;
			if (req.read) begin
				check_block("mem_rdata", mem_rdata, exp.rdata);
			end
			if (exp.writeback) begin                        // Writeback must come first
				check_flag("pmem.write", memory.access_log[n].write, 1'b1);
				check_addr("pmem.address", memory.access_log[n].address, exp.wb_address);
				check_block("pmem.wdata", memory.access_log[n].wdata, exp.wb_data);
				n++;
			end
			if (exp.fill) begin
				check_flag("pmem.read", memory.access_log[n].read, 1'b1);
				check_addr("pmem.address", memory.access_log[n].address,
					{req.address[15:5], 5'b0});
				n++;
			end
			checks++;
			if (memory.access_log.size() != n) begin
				errors++;
				$display("wrong number of memory accesses at %0t ns: %0d seen, %0d expected",
					$time, memory.access_log.size(), n);
			end
			checks++;
			if (exp.fill && !pmem_resp_prev) begin
				errors++;
				$display("miss answered at %0t ns, not one cycle after pmem_resp", $time);
			end else if (!exp.fill && req_cycles != 0) begin
				errors++;
				$display("hit answered at %0t ns after %0d cycles instead of at once",
					$time, req_cycles);
			end
			memory.access_log.delete();
		end
		if (reset || mem_resp) begin
			req_cycles = 0;
		end else if (req.read || req.write) begin
			req_cycles++;                                   // Still waiting for mem_resp
		end
		pmem_resp_prev <= pmem_resp;
	end

	// Present one request on a falling edge, hold it until mem_resp
	task automatic request(input logic is_write, input lc3b_pkg::lc3b_word address,
			input lc3b_pkg::lc3b_block wdata);
		@(negedge clk);
		req.read    = ~is_write;
		req.write   = is_write;
		req.address = address;
		req.wdata   = wdata;
		@(posedge clk);
		while (!mem_resp) @(posedge clk);
		@(negedge clk);
		req = '0;
	endtask

	function automatic lc3b_pkg::lc3b_block random_block();
		lc3b_pkg::lc3b_block b;
		for (int i = 0; i < 8; i++) begin
			b[i*32 +: 32] = $random(seed);
		end
		return b;
	endfunction

	task automatic end_test(input string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, errors - test_base);
		test_base = errors;
	endtask

	initial begin : stimulus
		logic [31:0] r;
		req   = '0;
		reset = 1'b1;
		for (int s = 0; s < l2_cache_pkg::num_sets; s++) begin
			ref_valid[s] = '0;
			ref_dirty[s] = '0;
		end
		ref_lru = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < 4; i++) begin                 // Sets 0 to 3 miss once each
			request(1'b0, {8'h10 + i[7:0], i[2:0], 5'h07}, '0);
		end
		for (int i = 0; i < 4; i++) begin                 // Now resident
			request(1'b0, {8'h10 + i[7:0], i[2:0], 5'h11}, '0);
		end
		end_test("cold reads");

		request(1'b1, 16'h1000, random_block());
		request(1'b0, 16'h101f, '0);
		end_test("write hit then read");

		request(1'b0, 16'h20a0, '0);                      // Set 5 fills both ways
		request(1'b0, 16'h21a0, '0);
		request(1'b0, 16'h22a0, '0);                      // Evicts tag 20
		request(1'b0, 16'h21a4, '0);                      // Retained tag hits
		request(1'b0, 16'h20a0, '0);                      // Evicted tag misses again
		end_test("lru replacement");

		request(1'b1, 16'h30c0, random_block());          // Dirty line in set 6
		request(1'b0, 16'h31c0, '0);
		request(1'b0, 16'h32c0, '0);                      // Forces writeback of tag 30
		request(1'b0, 16'h30c8, '0);                      // Written data back from memory
		end_test("dirty eviction");

		request(1'b1, 16'h40e0, random_block());          // Fill then overwrite
		request(1'b0, 16'h40e2, '0);
		end_test("write miss");

		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			request(r[10], {6'b011010, r[4:3], r[2:0], r[9:5]}, random_block());
		end
		end_test("random mix");

		$display("tests %0d, checks %0d, errors %0d", test_count, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Worst case per request is a writeback and a fill
	initial begin
		#(watchdog_ns);
		$display("Timeout, the cache stopped answering after %0d ns", watchdog_ns);
		$display("Verification failed");
		$finish;
	end

endmodule : l2_cache_tb

// File: l2_cache.f
src/lc3b_pkg.sv
src/l2_cache_pkg.sv
src/l2_cache_datapath.sv
src/l2_cache_control.sv
src/l2_cache.sv
tb/pmem_model.sv
tb/l2_cache_tb.sv
